// File: Bender.yml
package:
  name: sublane_driver

sources:
  # Shared package first
  - common/vlane_pkg.sv
  # Helper blocks
  - verilog/vrf_addr_counter.sv
  - verilog/byte_enable_gen.sv
  - verilog/lane_valid_tracker.sv
  - sequencer/sublane_sequencer.sv
  # Top level
  - verilog/sublane_driver.sv
  # Testbench
  - target: test
    files:
      - tests/sublane_driver_tb.sv

// File: common/vlane_pkg.sv
// Vector lane sequencer shared types

package vlane_pkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction and element encodings
    //////////////////////////////////////////////////////////////////////

    // Kind of instruction handled by the sequencer
    typedef enum logic [2:0] {
        NORMAL,         // Read, compute, write back
        STORE,          // Read only, store data
        INDEXED_STORE,  // Read data and index
        LOAD,           // Write beats from load unit
        INDEXED_LOAD    // Read index only
    } inst_type_e;

    // Element width, also the write data width
    typedef enum logic [1:0] {
        EW_BYTE = 2'd1,
        EW_HALF = 2'd2,
        EW_WORD = 2'd3
    } elem_width_e;

    //////////////////////////////////////////////////////////////////////
    // Sequencer states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE,           // Waiting for an instruction
        NORMAL_MODE,    // Reads followed by delayed writes
        READ_MODE,      // Stores and indexed load
        LOAD_MODE       // Load beats under valid/ready
    } seq_state_e;

    //////////////////////////////////////////////////////////////////////
    // Fixed constants
    //////////////////////////////////////////////////////////////////////

    localparam int BYTES_PER_WORD = 4;  // Lane word width
    localparam int RD_PORTS = 3;        // VRF read ports per lane group

endpackage

// File: sequencer/sublane_sequencer.sv
// Lane group instruction sequencer
`timescale 1ns/100ps

module sublane_sequencer #(
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256
) (
    input  logic                                           clk_i,
    input  logic                                           rst_i,
    input  logic                                           start_i,
    output logic                                           ready_o,
    input  vlane_pkg::inst_type_e                          inst_type_i,
    input  logic [$clog2(VLANE_NUM * MAX_VL_PER_LANE)-1:0] vl_i,
    input  logic [$clog2(MAX_VL_PER_LANE)-1:0]             inst_delay_i,
    input  vlane_pkg::elem_width_e                         vsew_i,
    input  vlane_pkg::elem_width_e                         wdata_width_i,
    input  logic                                           vector_mask_i,
    input  logic                                           load_valid_i,
    input  logic                                           load_last_i,
    output logic                                           ready_for_load_o,
    output logic                                           addr_load_o,
    output logic                                           rd_step_o,
    output logic                                           wr_step_o,
    output vlane_pkg::elem_width_e                         rd_width_o,
    output vlane_pkg::elem_width_e                         wr_width_o,
    output logic                                           write_o,
    output logic                                           load_mode_o,
    output logic                                           vrf_ren_o,
    output logic                                           store_data_valid_o,
    output logic                                           store_load_index_valid_o,
    output logic [$clog2(MAX_VL_PER_LANE)-1:0]             vmrf_addr_o,
    output logic                                           vmrf_wen_o
);
    import vlane_pkg::*;

    localparam int LANE_W = $clog2(VLANE_NUM);
    localparam int DLY_W  = $clog2(MAX_VL_PER_LANE);
    localparam int ROW_W  = DLY_W + 1;  // Row count reaches MAX_VL_PER_LANE
    localparam int CNT_W  = ROW_W + 1;  // Delay plus rows

    seq_state_e       state_q, state_d;
    logic             pending_q;      // Accepted, mode starts next cycle
    logic             accept;
    inst_type_e       type_q;
    elem_width_e      vsew_q, wdw_q;
    logic [DLY_W-1:0] delay_q;
    logic [ROW_W-1:0] rows_d, rows_q;
    logic             mask_q;
    logic [CNT_W-1:0] row_cnt_q;
    logic [CNT_W-1:0] end_cnt;        // First cycle past the last write
    logic [DLY_W-1:0] vmrf_cnt_q;
    logic             rd_active, wr_active, load_beat;

    assign accept = start_i && ready_o;
    assign rows_d = ROW_W'(vl_i >> LANE_W) + ROW_W'(|vl_i[LANE_W-1:0]);  // ceil(vl / lanes)

    //////////////////////////////////////////////////////////////////////
    // Instruction register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (accept) begin
            type_q  <= inst_type_i;
            rows_q  <= rows_d;
            delay_q <= inst_delay_i;
            vsew_q  <= vsew_i;
            wdw_q   <= wdata_width_i;
            mask_q  <= vector_mask_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Row windows
    //////////////////////////////////////////////////////////////////////
    assign end_cnt   = CNT_W'(delay_q) + CNT_W'(rows_q);
    assign rd_active = (state_q == NORMAL_MODE || state_q == READ_MODE)
                       && (row_cnt_q < CNT_W'(rows_q));
    assign wr_active = (state_q == NORMAL_MODE) && (row_cnt_q >= CNT_W'(delay_q))
                       && (row_cnt_q < end_cnt);
    assign load_beat = (state_q == LOAD_MODE) && load_valid_i;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pending_q) begin
                    case (type_q)
                        NORMAL:  state_d = NORMAL_MODE;
                        LOAD:    state_d = LOAD_MODE;
                        default: state_d = READ_MODE;  // Stores, indexed load
                    endcase
                end
            end
            NORMAL_MODE: if (row_cnt_q + 1'b1 >= end_cnt) state_d = IDLE;
            READ_MODE:   if (row_cnt_q + 1'b1 >= CNT_W'(rows_q)) state_d = IDLE;
            LOAD_MODE:   if (load_valid_i && load_last_i) state_d = IDLE;
            default:     state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q    <= IDLE;
            ready_o    <= 1'b1;
            pending_q  <= 1'b0;
            row_cnt_q  <= '0;
            vmrf_cnt_q <= '0;
        end else begin
            state_q   <= state_d;
            pending_q <= accept;
            if (accept) begin
                ready_o <= 1'b0;
            end else if (state_q != IDLE && state_d == IDLE) begin
                ready_o <= 1'b1;  // Back in the cycle after the last strobe
            end
            row_cnt_q  <= (state_q == IDLE) ? '0 : row_cnt_q + 1'b1;
            if (state_q == IDLE) begin
                vmrf_cnt_q <= '0;
            end else if (wr_active) begin
                vmrf_cnt_q <= vmrf_cnt_q + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Strobes
    //////////////////////////////////////////////////////////////////////
    assign addr_load_o = (state_q == IDLE) && ready_o;  // Last load on the accepting edge
    assign vrf_ren_o   = rd_active;
    assign rd_step_o   = rd_active;
    assign write_o     = wr_active || load_beat;
    assign wr_step_o   = wr_active || load_beat;
    assign load_mode_o      = (state_q == LOAD_MODE);
    assign ready_for_load_o = (state_q == LOAD_MODE);
    assign rd_width_o  = vsew_q;
    assign wr_width_o  = (state_q == LOAD_MODE) ? EW_WORD : wdw_q;  // Loads write whole words

    assign store_data_valid_o = rd_active && (type_q == STORE || type_q == INDEXED_STORE);
    assign store_load_index_valid_o = rd_active
                                      && (type_q == INDEXED_STORE || type_q == INDEXED_LOAD);

    assign vmrf_addr_o = vmrf_cnt_q;
    assign vmrf_wen_o  = wr_active && mask_q;

endmodule

// File: sublane_driver.f
common/vlane_pkg.sv
verilog/vrf_addr_counter.sv
verilog/byte_enable_gen.sv
verilog/lane_valid_tracker.sv
sequencer/sublane_sequencer.sv
verilog/sublane_driver.sv
tests/sublane_driver_tb.sv

// File: tests/sublane_driver_tb.sv
// Lane group driver testbench
`timescale 1ns/100ps

module sublane_driver_tb;
    import vlane_pkg::*;

    localparam int MEM_DEPTH       = 512;
    localparam int VLANE_NUM       = 8;
    localparam int MAX_VL_PER_LANE = 256;
    localparam int AW      = $clog2(MEM_DEPTH);
    localparam int VLW     = $clog2(VLANE_NUM * MAX_VL_PER_LANE);
    localparam int DW      = $clog2(MAX_VL_PER_LANE);
    localparam int TIMEOUT = 2000;  // Cycles per wait

    logic                                       clk_i, rst_i, start_i, ready_o;
    logic [VLW-1:0]                             vl_i;
    inst_type_e                                 inst_type_i;
    elem_width_e                                vsew_i, wdata_width_i;
    logic [DW-1:0]                              inst_delay_i, vmrf_addr_o;
    logic                                       vector_mask_i, vrf_ren_o, vmrf_wen_o;
    logic [RD_PORTS-1:0][AW-1:0]                vrf_start_raddr_i, vrf_raddr_o;
    logic [AW-1:0]                              vrf_start_waddr_i, vrf_waddr_o;
    logic [VLANE_NUM-1:0][BYTES_PER_WORD-1:0]   vrf_bwen_o, load_bwen_i;
    logic [VLANE_NUM-1:0]                       read_data_valid_o;
    logic                                       load_valid_i, load_last_i, ready_for_load_o;
    logic                                       store_data_valid_o, store_load_index_valid_o;

    // Instruction under test as the monitor expects it
    string                       cur_test;
    inst_type_e                  cur_type;
    int                          cur_vl, cur_delay;
    elem_width_e                 cur_vsew, cur_wdw;
    logic                        cur_mask;
    logic [RD_PORTS-1:0][AW-1:0] cur_raddr;
    logic [AW-1:0]               cur_waddr;
    int                          rd_cnt, wr_cnt, first_rd, cyc;
    integer                      seed = 32'hb72f;

    sublane_driver #(
        .MEM_DEPTH       (MEM_DEPTH),
        .VLANE_NUM       (VLANE_NUM),
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
    ) i_sublane_driver (.*);

    always #5 clk_i = ~clk_i;

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            fail_stop($sformatf("[FAIL] %s %s: expected %0h, actual %0h",
                                cur_test, what, exp, act));
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic int rows_needed(input int vl);
        return (vl + VLANE_NUM - 1) / VLANE_NUM;
    endfunction

    function automatic logic [AW-1:0] word_addr(input logic [AW-1:0] start, input int k,
                                                input elem_width_e w);
        int epw;
        epw = (w == EW_BYTE) ? 4 : (w == EW_HALF) ? 2 : 1;  // Elements per word
        return start + AW'(k / epw);
    endfunction

    function automatic logic [VLANE_NUM*4-1:0] enable_pattern(input elem_width_e w,
                                                              input int k);
        logic [3:0] p;
        case (w)
            EW_BYTE: p = 4'b0001 << (k % 4);
            EW_HALF: p = (k % 2 == 0) ? 4'b0011 : 4'b1100;
            default: p = 4'b1111;
        endcase
        return {VLANE_NUM{p}};  // Same pattern on every lane
    endfunction

    function automatic logic [VLANE_NUM-1:0] lane_valids(input int vl, input int k);
        logic [VLANE_NUM-1:0] v;
        for (int i = 0; i < VLANE_NUM; i++) v[i] = (k * VLANE_NUM + i < vl);
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Monitor compares every strobe cycle in order
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk_i) begin
        cyc = cyc + 1;
        if (rst_i) begin
            if (vrf_ren_o) begin
                if (rd_cnt == 0) first_rd = cyc;
                check_eq("read cycle", first_rd + rd_cnt, cyc);  // Consecutive rows
                for (int p = 0; p < RD_PORTS; p++) begin
                    check_eq("read address", word_addr(cur_raddr[p], rd_cnt, cur_vsew),
                             vrf_raddr_o[p]);
                end
                check_eq("lane valid", lane_valids(cur_vl, rd_cnt), read_data_valid_o);
                check_eq("store data valid",
                         cur_type == STORE || cur_type == INDEXED_STORE,
                         store_data_valid_o);
                check_eq("index valid",
                         cur_type == INDEXED_STORE || cur_type == INDEXED_LOAD,
                         store_load_index_valid_o);
                rd_cnt = rd_cnt + 1;
            end else begin
                check_eq("strobes off row",
                         0, {read_data_valid_o, store_data_valid_o, store_load_index_valid_o});
            end
            if ((cur_type == LOAD) ? (load_valid_i && ready_for_load_o) : (|vrf_bwen_o)) begin
                if (cur_type == LOAD) begin
                    check_eq("load address", word_addr(cur_waddr, wr_cnt, EW_WORD),
                             vrf_waddr_o);
                    check_eq("load enables", load_bwen_i, vrf_bwen_o);
                end else begin
                    check_eq("write cycle", first_rd + cur_delay + wr_cnt, cyc);
                    check_eq("write address", word_addr(cur_waddr, wr_cnt, cur_wdw),
                             vrf_waddr_o);
                    check_eq("byte enables", enable_pattern(cur_wdw, wr_cnt), vrf_bwen_o);
                    check_eq("vmrf address", wr_cnt, vmrf_addr_o);
                    check_eq("vmrf write", cur_mask, vmrf_wen_o);
                end
                wr_cnt = wr_cnt + 1;
            end else begin
                check_eq("write off row", 0, {vrf_bwen_o, vmrf_wen_o});
                if (ready_for_load_o) begin  // Address holds in a gap
                    check_eq("load address hold", word_addr(cur_waddr, wr_cnt, EW_WORD),
                             vrf_waddr_o);
                end
            end
        end
    end

    // Load beats with random gaps and the last beat flagged
    task automatic drive_load(input int beats);
        int   sent;
        int   wait_cnt;
        logic v;
        sent = 0;
        wait_cnt = 0;
        while (sent < beats) begin
            @(negedge clk_i);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) fail_stop("Timeout: load beats were not accepted");
            v = ready_for_load_o && (rand_range(0, 3) != 0);
            load_valid_i = v;
            load_bwen_i  = $random(seed);
            load_last_i  = v && (sent == beats - 1);
            if (v) sent++;
        end
        @(negedge clk_i);
        load_valid_i = 1'b0;
        load_last_i  = 1'b0;
        check_eq("load mode after last beat", 0, ready_for_load_o);
    endtask

    task automatic run_inst(input inst_type_e t, input int beats);
        int wait_cnt;
        int exp_rd;
        int exp_wr;
        cur_type  = t;
        cur_vl    = rand_range(1, 100);
        cur_delay = rand_range(0, 6);
        cur_vsew  = elem_width_e'(rand_range(1, 3));
        cur_wdw   = elem_width_e'(rand_range(1, 3));
        cur_mask  = rand_range(0, 1);
        for (int p = 0; p < RD_PORTS; p++) cur_raddr[p] = AW'(rand_range(0, MEM_DEPTH - 1));
        cur_waddr = AW'(rand_range(0, MEM_DEPTH - 1));
        rd_cnt = 0;
        wr_cnt = 0;
        exp_rd = (t == LOAD) ? 0 : rows_needed(cur_vl);
        exp_wr = (t == LOAD) ? beats : (t == NORMAL) ? rows_needed(cur_vl) : 0;
        start_i           = 1'b1;
        inst_type_i       = t;
        vl_i              = VLW'(cur_vl);
        inst_delay_i      = DW'(cur_delay);
        vsew_i            = cur_vsew;
        wdata_width_i     = cur_wdw;
        vector_mask_i     = cur_mask;
        vrf_start_raddr_i = cur_raddr;
        vrf_start_waddr_i = cur_waddr;
        @(negedge clk_i);
        start_i = 1'b0;
        check_eq("ready after accept", 0, ready_o);
        // Stray start with other fields while busy
        @(negedge clk_i);
        start_i           = 1'b1;
        inst_type_i       = NORMAL;
        vl_i              = VLW'(rand_range(1, 100));
        vrf_start_waddr_i = AW'(rand_range(0, MEM_DEPTH - 1));
        @(negedge clk_i);
        start_i = 1'b0;
        if (t == LOAD) drive_load(beats);
        wait_cnt = 0;
        while (!ready_o) begin
            @(negedge clk_i);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) fail_stop("Timeout: ready_o did not return high");
        end
        repeat (4) @(negedge clk_i);  // Idle window catches extra strobes
        check_eq("ready after idle", 1, ready_o);
        check_eq("read count", exp_rd, rd_cnt);
        check_eq("write count", exp_wr, wr_cnt);
    endtask

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b0;
        start_i = 1'b0;
        vl_i = '0;
        inst_type_i = NORMAL;
        vsew_i = EW_WORD;
        wdata_width_i = EW_WORD;
        inst_delay_i = '0;
        vector_mask_i = 1'b0;
        vrf_start_raddr_i = '0;
        vrf_start_waddr_i = '0;
        load_valid_i = 1'b0;
        load_last_i = 1'b0;
        load_bwen_i = '0;
        cur_type = NORMAL;
        cur_test = "reset";
        rd_cnt = 0;
        wr_cnt = 0;
        first_rd = 0;
        cyc = 0;
        repeat (3) @(negedge clk_i);
        rst_i = 1'b1;
        @(negedge clk_i);
        check_eq("ready", 1, ready_o);
        check_eq("controls", 0, {vrf_ren_o, vrf_bwen_o, vmrf_wen_o, store_data_valid_o,
                                 store_load_index_valid_o, ready_for_load_o});
        for (int n = 0; n < 12; n++) begin
            cur_test = $sformatf("normal %0d", n);
            run_inst(NORMAL, 0);
        end
        for (int n = 0; n < 4; n++) begin
            cur_test = $sformatf("store %0d", n);
            run_inst(STORE, 0);
            cur_test = $sformatf("indexed store %0d", n);
            run_inst(INDEXED_STORE, 0);
            cur_test = $sformatf("indexed load %0d", n);
            run_inst(INDEXED_LOAD, 0);
        end
        for (int n = 0; n < 6; n++) begin
            cur_test = $sformatf("load %0d", n);
            run_inst(LOAD, rand_range(1, 20));
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: verilog/byte_enable_gen.sv
// Lane byte enable generator
`timescale 1ns/100ps

module byte_enable_gen #(
    parameter int VLANE_NUM = 8
) (
    input  logic                                             clk_i,
    input  logic                                             rst_i,
    input  logic                                             write_i,
    input  vlane_pkg::elem_width_e                           width_i,
    input  logic                                             load_mode_i,
    input  logic [VLANE_NUM-1:0][vlane_pkg::BYTES_PER_WORD-1:0] load_bwen_i,
    output logic [VLANE_NUM-1:0][vlane_pkg::BYTES_PER_WORD-1:0] lane_bwen_o
);
    import vlane_pkg::*;

    logic [BYTES_PER_WORD-1:0] rot4_q;   // One-hot byte pointer
    logic [1:0]                rot2_q;   // Low or high halfword
    logic [BYTES_PER_WORD-1:0] pattern;

    //////////////////////////////////////////////////////////////////////
    // Rotators, restart whenever a write burst ends
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rot4_q <= BYTES_PER_WORD'(1);
            rot2_q <= 2'b01;
        end else if (write_i) begin
            rot4_q <= {rot4_q[BYTES_PER_WORD-2:0], rot4_q[BYTES_PER_WORD-1]};
            rot2_q <= {rot2_q[0], rot2_q[1]};
        end else begin
            rot4_q <= BYTES_PER_WORD'(1);
            rot2_q <= 2'b01;
        end
    end

    // Pattern for one lane
    always_comb begin
        case (width_i)
            EW_BYTE: pattern = rot4_q;
            EW_HALF: pattern = {{(BYTES_PER_WORD / 2){rot2_q[1]}},
                                {(BYTES_PER_WORD / 2){rot2_q[0]}}};
            EW_WORD: pattern = '1;
            default: pattern = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Per-lane select
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < VLANE_NUM; i++) begin
            if (!write_i) begin
                lane_bwen_o[i] = '0;
            end else if (load_mode_i) begin
                lane_bwen_o[i] = load_bwen_i[i];  // Load unit decides
            end else begin
                lane_bwen_o[i] = pattern;
            end
        end
    end

endmodule

// File: verilog/lane_valid_tracker.sv
// Lane read data valid tracker
`timescale 1ns/100ps

module lane_valid_tracker #(
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256
) (
    input  logic                                           clk_i,
    input  logic                                           rst_i,
    input  logic                                           load_i,
    input  logic [$clog2(VLANE_NUM * MAX_VL_PER_LANE)-1:0] vl_i,
    input  logic                                           row_i,
    output logic [VLANE_NUM-1:0]                           lane_valid_o
);

    localparam int VL_W = $clog2(VLANE_NUM * MAX_VL_PER_LANE);

    logic [VL_W-1:0] rem_q;  // Elements not yet read

    // Remaining length, one row of lanes per read
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rem_q <= '0;
        end else if (load_i) begin
            rem_q <= vl_i;
        end else if (row_i) begin
            // Saturate on the partial last row
            rem_q <= (rem_q > VL_W'(VLANE_NUM)) ? rem_q - VL_W'(VLANE_NUM) : '0;
        end
    end

    always_comb begin
        for (int i = 0; i < VLANE_NUM; i++) begin
            lane_valid_o[i] = row_i && (rem_q > VL_W'(i));
        end
    end

endmodule

// File: verilog/sublane_driver.sv
// Vector lane group driver
`timescale 1ns/100ps

module sublane_driver #(
    parameter int MEM_DEPTH       = 512,
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256
) (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  logic                                                start_i,
    output logic                                                ready_o,
    input  logic [$clog2(VLANE_NUM * MAX_VL_PER_LANE)-1:0]      vl_i,
    input  vlane_pkg::inst_type_e                               inst_type_i,
    input  vlane_pkg::elem_width_e                              vsew_i,
    input  vlane_pkg::elem_width_e                              wdata_width_i,
    input  logic [$clog2(MAX_VL_PER_LANE)-1:0]                  inst_delay_i,
    input  logic                                                vector_mask_i,
    input  logic [vlane_pkg::RD_PORTS-1:0][$clog2(MEM_DEPTH)-1:0] vrf_start_raddr_i,
    input  logic [$clog2(MEM_DEPTH)-1:0]                        vrf_start_waddr_i,
    output logic                                                vrf_ren_o,
    output logic [vlane_pkg::RD_PORTS-1:0][$clog2(MEM_DEPTH)-1:0] vrf_raddr_o,
    output logic [$clog2(MEM_DEPTH)-1:0]                        vrf_waddr_o,
    output logic [VLANE_NUM-1:0][vlane_pkg::BYTES_PER_WORD-1:0] vrf_bwen_o,
    output logic [VLANE_NUM-1:0]                                read_data_valid_o,
    output logic [$clog2(MAX_VL_PER_LANE)-1:0]                  vmrf_addr_o,
    output logic                                                vmrf_wen_o,
    input  logic                                                load_valid_i,
    input  logic                                                load_last_i,
    output logic                                                ready_for_load_o,
    input  logic [VLANE_NUM-1:0][vlane_pkg::BYTES_PER_WORD-1:0] load_bwen_i,
    output logic                                                store_data_valid_o,
    output logic                                                store_load_index_valid_o
);
    import vlane_pkg::*;

    logic        addr_load, rd_step, wr_step, write, load_mode;
    elem_width_e rd_width, wr_width;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////
    sublane_sequencer #(
        .VLANE_NUM       (VLANE_NUM),
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
    ) i_sublane_sequencer (
        .clk_i, .rst_i, .start_i, .ready_o,
        .inst_type_i, .vl_i, .inst_delay_i, .vsew_i, .wdata_width_i, .vector_mask_i,
        .load_valid_i, .load_last_i, .ready_for_load_o,
        .addr_load_o (addr_load),
        .rd_step_o   (rd_step),
        .wr_step_o   (wr_step),
        .rd_width_o  (rd_width),
        .wr_width_o  (wr_width),
        .write_o     (write),
        .load_mode_o (load_mode),
        .vrf_ren_o, .store_data_valid_o, .store_load_index_valid_o,
        .vmrf_addr_o, .vmrf_wen_o
    );

    //////////////////////////////////////////////////////////////////////
    // Address counters, one per read port plus the write port
    //////////////////////////////////////////////////////////////////////
    for (genvar p = 0; p < RD_PORTS; p++) begin : g_rd_cnt
        vrf_addr_counter #(.MEM_DEPTH(MEM_DEPTH)) i_rd_cnt (
            .clk_i, .rst_i,
            .load_i       (addr_load),
            .start_addr_i (vrf_start_raddr_i[p]),
            .width_i      (rd_width),
            .step_i       (rd_step),
            .addr_o       (vrf_raddr_o[p])
        );
    end

    vrf_addr_counter #(.MEM_DEPTH(MEM_DEPTH)) i_wr_cnt (
        .clk_i, .rst_i,
        .load_i       (addr_load),
        .start_addr_i (vrf_start_waddr_i),
        .width_i      (wr_width),
        .step_i       (wr_step),
        .addr_o       (vrf_waddr_o)
    );

    // Write enables and read valids
    byte_enable_gen #(.VLANE_NUM(VLANE_NUM)) i_byte_enable_gen (
        .clk_i, .rst_i,
        .write_i     (write),
        .width_i     (wr_width),
        .load_mode_i (load_mode),
        .load_bwen_i,
        .lane_bwen_o (vrf_bwen_o)
    );

    lane_valid_tracker #(
        .VLANE_NUM       (VLANE_NUM),
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
    ) i_lane_valid_tracker (
        .clk_i, .rst_i,
        .load_i       (addr_load),
        .vl_i,
        .row_i        (vrf_ren_o),  // One row per read cycle
        .lane_valid_o (read_data_valid_o)
    );

endmodule

// File: verilog/vrf_addr_counter.sv
// VRF word address counter
`timescale 1ns/100ps

module vrf_addr_counter #(
    parameter int MEM_DEPTH = 512
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         load_i,
    input  logic [$clog2(MEM_DEPTH)-1:0] start_addr_i,
    input  vlane_pkg::elem_width_e       width_i,
    input  logic                         step_i,
    output logic [$clog2(MEM_DEPTH)-1:0] addr_o
);
    import vlane_pkg::*;

    localparam int SUB_W = $clog2(BYTES_PER_WORD);

    logic [SUB_W-1:0] elem_q;     // Element index inside current word
    logic [SUB_W-1:0] elem_last;  // Last element index for this width

    // Elements per word minus one
    always_comb begin
        case (width_i)
            EW_BYTE: elem_last = SUB_W'(BYTES_PER_WORD - 1);
            EW_HALF: elem_last = SUB_W'(BYTES_PER_WORD / 2 - 1);
            default: elem_last = '0;  // Word, one element per word
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_o <= '0;
            elem_q <= '0;
        end else if (load_i) begin
            addr_o <= start_addr_i;
            elem_q <= '0;
        end else if (step_i) begin
            if (elem_q == elem_last) begin  // Word filled, move on
                elem_q <= '0;
                addr_o <= addr_o + 1'b1;
            end else begin
                elem_q <= elem_q + 1'b1;
            end
        end
    end

endmodule
